// File: sources.f
+incdir+.
routerPkg.sv
roundRobinArbiter.sv
inputPort.sv
switchAllocator.sv
routerTop.sv
tbRouter.sv

// File: Bender.yml
package:
  name: mesh_router

sources:
  - include_dirs:
      - .
    files:
      - routerPkg.sv
      - roundRobinArbiter.sv
      - inputPort.sv
      - switchAllocator.sv
      - routerTop.sv
  - target: test
    include_dirs:
      - .
    files:
      - tbRouter.sv

// File: tbVectors.svh
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

// columns: test name, input port, input packet, expected output port, expected value
// packets are makePacket(xDir, yDir, xHops, yHops, payload), pe values are the payload
task automatic loadVectors();
    addVector("peToEast", routerPkg::portPe, makePacket(1, 0, 2, 1, 12'h123),
              routerPkg::portEast, makePacket(1, 0, 1, 1, 12'h123));
    addVector("peToWest", routerPkg::portPe, makePacket(0, 1, 1, 2, 12'h456),
              routerPkg::portWest, makePacket(0, 1, 0, 2, 12'h456));
    addVector("westToEast", routerPkg::portWest, makePacket(1, 1, 3, 0, 12'h789),
              routerPkg::portEast, makePacket(1, 1, 2, 0, 12'h789));
    addVector("westToEastLastHop", routerPkg::portWest, makePacket(1, 0, 1, 3, 12'hABC),
              routerPkg::portEast, makePacket(1, 0, 0, 3, 12'hABC));
    addVector("eastToWest", routerPkg::portEast, makePacket(0, 0, 2, 0, 12'hDEF),
              routerPkg::portWest, makePacket(0, 0, 1, 0, 12'hDEF));
    addVector("peToNorth", routerPkg::portPe, makePacket(0, 0, 0, 2, 12'h111),
              routerPkg::portNorth, makePacket(0, 0, 0, 1, 12'h111));
    addVector("peToSouth", routerPkg::portPe, makePacket(1, 1, 0, 3, 12'h222),
              routerPkg::portSouth, makePacket(1, 1, 0, 2, 12'h222));
    addVector("westToNorth", routerPkg::portWest, makePacket(1, 0, 0, 1, 12'h333),
              routerPkg::portNorth, makePacket(1, 0, 0, 0, 12'h333));
    addVector("eastToSouth", routerPkg::portEast, makePacket(0, 1, 0, 2, 12'h444),
              routerPkg::portSouth, makePacket(0, 1, 0, 1, 12'h444));
    addVector("northToSouth", routerPkg::portNorth, makePacket(0, 1, 0, 3, 12'h555),
              routerPkg::portSouth, makePacket(0, 1, 0, 2, 12'h555));
    addVector("southToNorth", routerPkg::portSouth, makePacket(1, 0, 0, 1, 12'h666),
              routerPkg::portNorth, makePacket(1, 0, 0, 0, 12'h666));
    addVector("westToPe", routerPkg::portWest, makePacket(1, 0, 0, 0, 12'h777),
              routerPkg::portPe, 20'h00777);
    addVector("eastToPe", routerPkg::portEast, makePacket(0, 1, 0, 0, 12'h888),
              routerPkg::portPe, 20'h00888);
    addVector("northToPe", routerPkg::portNorth, makePacket(0, 1, 0, 0, 12'h999),
              routerPkg::portPe, 20'h00999);
    addVector("southToPe", routerPkg::portSouth, makePacket(1, 0, 0, 0, 12'hAAA),
              routerPkg::portPe, 20'h00AAA);
    addVector("peToPe", routerPkg::portPe, makePacket(0, 0, 0, 0, 12'hBBB),
              routerPkg::portPe, 20'h00BBB);
    addVector("peToEastFull", routerPkg::portPe, makePacket(1, 1, 3, 3, 12'hCCC),
              routerPkg::portEast, makePacket(1, 1, 2, 3, 12'hCCC));
    addVector("westToSouth", routerPkg::portWest, makePacket(1, 1, 0, 3, 12'hDDD),
              routerPkg::portSouth, makePacket(1, 1, 0, 2, 12'hDDD));
    addVector("eastToNorth", routerPkg::portEast, makePacket(0, 0, 0, 3, 12'hEEE),
              routerPkg::portNorth, makePacket(0, 0, 0, 2, 12'hEEE));
    addVector("peToWestThenY", routerPkg::portPe, makePacket(0, 0, 3, 1, 12'hF0F),
              routerPkg::portWest, makePacket(0, 0, 2, 1, 12'hF0F));
endtask

`endif

// File: tbRouter.sv
`timescale 1ns/1ps

module tbRouter;

    logic               clk;
    logic               reset;
    logic               inReq       [routerPkg::numPorts];
    routerPkg::packetT  inData      [routerPkg::numPorts];
    logic               inAck       [routerPkg::numPorts];
    logic               linkOutReq  [routerPkg::numPorts-1];
    routerPkg::packetT  linkOutData [routerPkg::numPorts-1];
    logic               linkOutAck  [routerPkg::numPorts-1];
    logic               peOutReq;
    routerPkg::payloadT peOutData;
    logic               peOutAck;

    // vector table, one entry per index across the queues
    string       vecName   [$];
    int          vecIn     [$];
    logic [19:0] vecPacket [$];
    int          vecOut    [$];
    logic [19:0] vecExpect [$];

    int          expectCount [routerPkg::numPorts];
    int          seenCount   [routerPkg::numPorts];  // req rises seen by the monitor
    logic        lastReq     [routerPkg::numPorts];
    logic [19:0] lastData    [routerPkg::numPorts];

    routerTop dut0 (
        .clk         (clk),
        .reset       (reset),
        .inReq       (inReq),
        .inData      (inData),
        .inAck       (inAck),
        .linkOutReq  (linkOutReq),
        .linkOutData (linkOutData),
        .linkOutAck  (linkOutAck),
        .peOutReq    (peOutReq),
        .peOutData   (peOutData),
        .peOutAck    (peOutAck)
    );

    always #50 clk = ~clk;

    task automatic addVector(string name, int inPort, logic [19:0] packet, int outPort,
                             logic [19:0] expected);
        vecName.push_back(name);
        vecIn.push_back(inPort);
        vecPacket.push_back(packet);
        vecOut.push_back(outPort);
        vecExpect.push_back(expected);
    endtask

    // right-aligned thermometer count, two hops is 011
    function automatic logic [2:0] thermometer(int hops);
        logic [3:0] t;
        t = (4'd1 << hops) - 4'd1;
        return t[2:0];
    endfunction

    // fields in wire order, x dir first
    function automatic logic [19:0] makePacket(logic xDir, logic yDir, int xHops, int yHops,
                                               logic [11:0] payload);
        return {xDir, yDir, thermometer(xHops), thermometer(yHops), payload};
    endfunction

    `include "tbVectors.svh"

    function automatic logic outReq(int p);
        if (p == routerPkg::portPe) return peOutReq;
        return linkOutReq[p];
    endfunction

    function automatic logic [19:0] outData(int p);
        if (p == routerPkg::portPe) return {8'h00, peOutData};
        return linkOutData[p];
    endfunction

    task automatic setAck(int p, logic value);
        if (p == routerPkg::portPe) begin
            peOutAck = value;
        end else begin
            linkOutAck[p] = value;
        end
    endtask

    task automatic abortRun();
        $display("TEST FAILED");
        $fatal(1);
    endtask

    task automatic checkValue(string name, logic [19:0] expected, logic [19:0] actual);
        if (expected !== actual) begin
            $display("Mismatch in %s: expected %h, actual %h", name, expected, actual);
            abortRun();
        end
    endtask

    task automatic waitInAck(int p, logic level);
        int cycles;
        cycles = 0;
        while (inAck[p] !== level && cycles <= 200) begin
            @(negedge clk);
            cycles++;
        end
        if (inAck[p] !== level) begin
            $display("Timeout: ack of input %0d never went to %0b", p, level);
            abortRun();
        end
    endtask

    task automatic waitOutReq(int p, logic level);
        int cycles;
        cycles = 0;
        while (outReq(p) !== level && cycles <= 200) begin
            @(negedge clk);
            cycles++;
        end
        if (outReq(p) !== level) begin
            $display("Timeout: req of output %0d never went to %0b", p, level);
            abortRun();
        end
    endtask

    // four-phase sender on one input
    task automatic sendPacket(int p, logic [19:0] packet);
        inData[p] = packet;
        inReq[p]  = 1'b1;
        waitInAck(p, 1'b1);
        inReq[p] = 1'b0;
        waitInAck(p, 1'b0);
    endtask

    // four-phase receiver with a random ack delay
    task automatic receivePacket(int p, output logic [19:0] value);
        int delay;
        waitOutReq(p, 1'b1);
        delay = $urandom % 6;
        repeat (delay) @(negedge clk);
        value = outData(p);
        setAck(p, 1'b1);
        waitOutReq(p, 1'b0);
        setAck(p, 1'b0);
    endtask

    // west and pe both aim at east in the same cycle
    task automatic runContention();
        logic [19:0] fromWest;
        logic [19:0] fromPe;
        logic [19:0] wantWest;
        logic [19:0] wantPe;
        logic [19:0] gotFirst;
        logic [19:0] gotSecond;
        fromWest = makePacket(1, 0, 1, 2, 12'h5A5);
        wantWest = makePacket(1, 0, 0, 2, 12'h5A5);
        fromPe   = makePacket(1, 1, 2, 0, 12'hA5A);
        wantPe   = makePacket(1, 1, 1, 0, 12'hA5A);
        fork
            sendPacket(routerPkg::portWest, fromWest);
            sendPacket(routerPkg::portPe, fromPe);
            begin
                receivePacket(routerPkg::portEast, gotFirst);
                receivePacket(routerPkg::portEast, gotSecond);
            end
        join
        expectCount[routerPkg::portEast] += 2;
        // order is up to the arbiter, compare as a set
        if (gotFirst === wantWest) begin
            checkValue("contention", wantPe, gotSecond);
        end else begin
            checkValue("contention", wantPe, gotFirst);
            checkValue("contention", wantWest, gotSecond);
        end
    endtask

    // output side monitor, data must hold while req is high
    always @(negedge clk) begin
        for (int p = 0; p < routerPkg::numPorts; p++) begin
            logic        req;
            logic [19:0] data;
            req  = outReq(p);
            data = outData(p);
            if (!reset) begin
                if (lastReq[p] && req) begin
                    checkValue($sformatf("held data on output %0d", p), lastData[p], data);
                end
                if (!lastReq[p] && req) seenCount[p]++;
            end
            lastReq[p]  = reset ? 1'b0 : req;
            lastData[p] = data;
        end
    end

    initial begin
        logic [19:0] got;
        void'($urandom(59498));
        clk      = 1'b0;
        reset    = 1'b1;
        peOutAck = 1'b0;
        for (int p = 0; p < routerPkg::numPorts; p++) begin
            inReq[p]       = 1'b0;
            inData[p]      = '0;
            expectCount[p] = 0;
            seenCount[p]   = 0;
            lastReq[p]     = 1'b0;
            lastData[p]    = '0;
            if (p < routerPkg::numPorts - 1) linkOutAck[p] = 1'b0;
        end
        loadVectors();

        repeat (16) @(negedge clk);
        reset = 1'b0;

        for (int p = 0; p < routerPkg::numPorts; p++) begin
            checkValue($sformatf("reset inAck %0d", p), 1'b0, inAck[p]);
            checkValue($sformatf("reset out req %0d", p), 1'b0, outReq(p));
        end

        for (int i = 0; i < vecName.size(); i++) begin
            fork
                sendPacket(vecIn[i], vecPacket[i]);
                receivePacket(vecOut[i], got);
            join
            expectCount[vecOut[i]]++;
            checkValue(vecName[i], vecExpect[i], got);
        end

        runContention();

        repeat (10) @(negedge clk);  // room for a stray duplicate to show up
        for (int p = 0; p < routerPkg::numPorts; p++) begin
            checkValue($sformatf("packet count output %0d", p), expectCount[p], seenCount[p]);
        end

        $display("TEST OK");
        $finish;
    end

endmodule

// File: routerTop.sv
`timescale 1ns/1ps

module routerTop (
    input  logic               clk,
    input  logic               reset,

    // inputs from the four links and the pe, indexed by portE
    input  logic               inReq       [routerPkg::numPorts],
    input  routerPkg::packetT  inData      [routerPkg::numPorts],
    output logic               inAck       [routerPkg::numPorts],

    // link outputs, west east north south
    output logic               linkOutReq  [routerPkg::numPorts-1],
    output routerPkg::packetT  linkOutData [routerPkg::numPorts-1],
    input  logic               linkOutAck  [routerPkg::numPorts-1],

    // local pe output, payload only
    output logic               peOutReq,
    output routerPkg::payloadT peOutData,
    input  logic               peOutAck
);

    // input port to switch allocator
    logic              routeValid  [routerPkg::numPorts];
    routerPkg::portE   routePort   [routerPkg::numPorts];
    routerPkg::packetT routePacket [routerPkg::numPorts];
    logic              grant       [routerPkg::numPorts];

    // one identical receiver per direction, pe included
    for (genvar p = 0; p < routerPkg::numPorts; p++) begin : genIn
        inputPort inPort (
            .clk         (clk),
            .reset       (reset),
            .inReq       (inReq[p]),
            .inData      (inData[p]),
            .inAck       (inAck[p]),
            .routeValid  (routeValid[p]),
            .routePort   (routePort[p]),
            .routePacket (routePacket[p]),
            .grant       (grant[p])
        );
    end

    switchAllocator alloc0 (
        .clk         (clk),
        .reset       (reset),
        .routeValid  (routeValid),
        .routePort   (routePort),
        .routePacket (routePacket),
        .grant       (grant),
        .linkOutReq  (linkOutReq),
        .linkOutData (linkOutData),
        .linkOutAck  (linkOutAck),
        .peOutReq    (peOutReq),
        .peOutData   (peOutData),
        .peOutAck    (peOutAck)
    );

endmodule

// File: switchAllocator.sv
`timescale 1ns/1ps

module switchAllocator (
    input  logic               clk,
    input  logic               reset,

    // offers from the input ports, indexed by input
    input  logic               routeValid  [routerPkg::numPorts],
    input  routerPkg::portE    routePort   [routerPkg::numPorts],
    input  routerPkg::packetT  routePacket [routerPkg::numPorts],
    output logic               grant       [routerPkg::numPorts],

    output logic               linkOutReq  [routerPkg::numPorts-1],
    output routerPkg::packetT  linkOutData [routerPkg::numPorts-1],
    input  logic               linkOutAck  [routerPkg::numPorts-1],

    output logic               peOutReq,
    output routerPkg::payloadT peOutData,
    input  logic               peOutAck
);

    // arbGrant[output][input]
    routerPkg::portMaskT arbGrant [routerPkg::numPorts];

    for (genvar o = 0; o < routerPkg::numPorts; o++) begin : genOut
        routerPkg::outStateE state;
        routerPkg::portMaskT request;
        routerPkg::packetT   winPacket;
        logic                idle;
        logic                ackIn;
        logic                load;

        assign idle = (state == routerPkg::outIdle);
        assign load = idle && |arbGrant[o];

        // inputs whose route points here, only offered while the sender is free
        always_comb begin
            request = '0;
            for (int i = 0; i < routerPkg::numPorts; i++) begin
                request[i] = idle && routeValid[i] && (routePort[i] == routerPkg::portE'(o));
            end
        end

        roundRobinArbiter arb (
            .clk     (clk),
            .reset   (reset),
            .request (request),
            .advance (idle),
            .grant   (arbGrant[o])
        );

        // grant is one-hot, so a plain priority mux is enough
        always_comb begin
            winPacket = '0;
            for (int i = 0; i < routerPkg::numPorts; i++) begin
                if (arbGrant[o][i]) begin
                    winPacket = routePacket[i];
                end
            end
        end

        // four-phase sender, req is high exactly in outReqHigh
        always_ff @(posedge clk) begin
            if (reset) begin
                state <= routerPkg::outIdle;
            end else begin
                case (state)
                    routerPkg::outIdle: begin
                        if (load) begin
                            state <= routerPkg::outReqHigh;
                        end
                    end
                    routerPkg::outReqHigh: begin
                        if (ackIn) begin
                            state <= routerPkg::outWaitAckLow;  // drop req
                        end
                    end
                    routerPkg::outWaitAckLow: begin
                        if (!ackIn) begin
                            state <= routerPkg::outIdle;
                        end
                    end
                    default: state <= routerPkg::outIdle;
                endcase
            end
        end

        if (o == routerPkg::portPe) begin : genPe
            routerPkg::payloadT dataReg;

            // header is spent, the pe only sees the payload
            always_ff @(posedge clk) begin
                if (load) begin
                    dataReg <= winPacket[routerPkg::yHopLoc+1 +: routerPkg::payloadWidth];
                end
            end

            assign ackIn     = peOutAck;
            assign peOutReq  = (state == routerPkg::outReqHigh);
            assign peOutData = dataReg;
        end else begin : genLink
            routerPkg::packetT dataReg;   // held for the whole handshake

            always_ff @(posedge clk) begin
                if (load) begin
                    dataReg <= winPacket;
                end
            end

            assign ackIn          = linkOutAck[o];
            assign linkOutReq[o]  = (state == routerPkg::outReqHigh);
            assign linkOutData[o] = dataReg;
        end
    end

    // fold the per-output grants back onto each input
    for (genvar i = 0; i < routerPkg::numPorts; i++) begin : genGrant
        routerPkg::portMaskT column;   // which outputs granted input i

        always_comb begin
            for (int o = 0; o < routerPkg::numPorts; o++) begin
                column[o] = arbGrant[o][i];
            end
        end

        assign grant[i] = |column;

        // an input offers one route, so at most one output may take it
        singleGrant: assert property (
            @(posedge clk) disable iff (reset)
            $onehot0(column)
        );
    end

endmodule

// File: inputPort.sv
`timescale 1ns/1ps

module inputPort (
    input  logic              clk,
    input  logic              reset,
    input  logic              inReq,
    input  routerPkg::packetT inData,
    output logic              inAck,
    output logic              routeValid,
    output routerPkg::portE   routePort,
    output routerPkg::packetT routePacket,
    input  logic              grant
);

    routerPkg::inStateE state;
    routerPkg::packetT  bufPacket;    // the one packet this port can hold
    routerPkg::portE    nextPort;
    routerPkg::packetT  nextPacket;

    // xy routing: x hops first, then y hops, then the local pe
    always_comb begin
        nextPacket = bufPacket;
        if (bufPacket[routerPkg::xHopLoc]) begin
            if (bufPacket[routerPkg::xDirLoc]) begin
                nextPort = routerPkg::portEast;
            end else begin
                nextPort = routerPkg::portWest;
            end
            // thermometer count down, a zero enters at the top
            nextPacket[routerPkg::xHopLoc -: routerPkg::hopWidth] =
                bufPacket[routerPkg::xHopLoc -: routerPkg::hopWidth] >> 1;
        end else if (bufPacket[routerPkg::yHopLoc]) begin
            if (bufPacket[routerPkg::yDirLoc]) begin
                nextPort = routerPkg::portSouth;
            end else begin
                nextPort = routerPkg::portNorth;
            end
            nextPacket[routerPkg::yHopLoc -: routerPkg::hopWidth] =
                bufPacket[routerPkg::yHopLoc -: routerPkg::hopWidth] >> 1;
        end else begin
            nextPort = routerPkg::portPe;  // arrived, switch strips the header
        end
    end

    // receive handshake and grant tracking
    always_ff @(posedge clk) begin
        if (reset) begin
            state <= routerPkg::inIdle;
            inAck <= 1'b0;
        end else begin
            // phase 4, sender has let go of req
            if (inAck && !inReq) begin
                inAck <= 1'b0;
            end

            case (state)
                routerPkg::inIdle: begin
                    if (inReq) begin
                        state <= routerPkg::inRoute;
                    end
                end
                routerPkg::inRoute: begin
                    inAck <= 1'b1;               // data is safe in bufPacket
                    state <= routerPkg::inWaitGrant;
                end
                routerPkg::inWaitGrant: begin
                    if (grant) begin
                        state <= routerPkg::inAckLow;
                    end
                end
                routerPkg::inAckLow: begin
                    // ack already low, or dropping at this edge
                    if (!inAck || !inReq) begin
                        state <= routerPkg::inIdle;
                    end
                end
                default: state <= routerPkg::inIdle;
            endcase
        end
    end

    // packet buffer and registered route
    always_ff @(posedge clk) begin
        if (state == routerPkg::inIdle && inReq) begin
            bufPacket <= inData;
        end
        if (state == routerPkg::inRoute) begin
            routePort   <= nextPort;
            routePacket <= nextPacket;
        end
    end

    assign routeValid = (state == routerPkg::inWaitGrant);

    // the switch may sample the offered route in any cycle until it grants
    offerStable: assert property (
        @(posedge clk) disable iff (reset)
        routeValid && !grant |=> $stable(routePacket) && $stable(routePort)
    );

endmodule

// File: roundRobinArbiter.sv
`timescale 1ns/1ps

module roundRobinArbiter (
    input  logic                clk,
    input  logic                reset,
    input  routerPkg::portMaskT request,
    input  logic                advance,
    output routerPkg::portMaskT grant
);

    routerPkg::portE pointer;   // highest priority requester this cycle
    routerPkg::portE winner;

    // first requester at or after the pointer, wrapping around
    always_comb begin
        int   idx;
        logic found;
        grant  = '0;
        winner = pointer;
        found  = 1'b0;
        for (int i = 0; i < routerPkg::numPorts; i++) begin
            idx = (int'(pointer) + i) % routerPkg::numPorts;
            if (!found && request[idx]) begin
                grant[idx] = 1'b1;
                winner     = routerPkg::portE'(idx);
                found      = 1'b1;
            end
        end
    end

    // winner drops to lowest priority once its grant is taken
    always_ff @(posedge clk) begin
        if (reset) begin
            pointer <= routerPkg::portWest;
        end else if (advance && |grant) begin
            if (winner == routerPkg::portPe) begin
                pointer <= routerPkg::portWest;
            end else begin
                pointer <= routerPkg::portE'(winner + 3'd1);
            end
        end
    end

    grantLegal: assert property (
        @(posedge clk) disable iff (reset)
        $onehot0(grant) && ((grant & ~request) == '0)
    );

endmodule

// File: routerPkg.sv
package routerPkg;

    // packet layout, bit 0 is the msb
    //   [0]     x direction, 0 = west, 1 = east
    //   [1]     y direction, 0 = north, 1 = south
    //   [2:4]   x hop count, right-aligned thermometer
    //   [5:7]   y hop count, right-aligned thermometer
    //   [8:19]  payload

    localparam int packetWidth  = 20;
    localparam int xDirLoc      = 0;
    localparam int yDirLoc      = 1;
    localparam int xHopLoc      = 4;  // last bit of the x hop field
    localparam int yHopLoc      = 7;  // last bit of the y hop field
    localparam int hopWidth     = 3;
    localparam int payloadWidth = 12;

    localparam int numPorts     = 5;  // four links plus the local pe

    typedef logic [0:packetWidth-1] packetT;     // same bit order as the link wires
    typedef logic [payloadWidth-1:0] payloadT;   // natural order for the pe

    // port index, also names the route of a packet
    typedef enum logic [2:0] {
        portWest  = 3'd0,
        portEast  = 3'd1,
        portNorth = 3'd2,
        portSouth = 3'd3,
        portPe    = 3'd4
    } portE;

    // one bit per port, bit n belongs to portE value n
    typedef logic [numPorts-1:0] portMaskT;

    // receive side of an input port
    typedef enum logic [1:0] {
        inIdle,       // waiting for req
        inRoute,      // packet captured, route being computed
        inWaitGrant,  // route offered to the switch
        inAckLow      // granted, finishing the handshake
    } inStateE;

    // send side of an output port
    typedef enum logic [1:0] {
        outIdle,        // free, may take a new packet
        outReqHigh,     // req up, waiting for ack
        outWaitAckLow   // req down, waiting for ack to fall
    } outStateE;

endpackage
